// ==== rtl/decode_defines.svh ====
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// ########################################
// cluster sizing.
// ########################################

// number of decode lanes, a power of two.
`define LANES 4

// entries per lane queue and per collector return buffer.
`define LANE_DEPTH 2

// entries in the distributor input buffer.
`define FETCH_DEPTH 4

// largest output credit count the consumer may grant.
`define UOP_CREDITS_MAX 8

// derived widths.
`define LANE_PTR_W ($clog2(`LANES))
`define LANE_CREDIT_W ($clog2(`LANE_DEPTH + 1))
`define UOP_CREDIT_W ($clog2(`UOP_CREDITS_MAX + 1))

`endif

// ==== rtl/isaPkg.sv ====
package isaPkg;

    // ########################################
    // encoding formats and opcodes.
    // ########################################

    // bit 31 set means immediate, else bits 31:30 pick register or jump.
    typedef enum logic [1:0] {
        regFormat  = 2'b00,
        jumpFormat = 2'b01,
        immFormat  = 2'b10
    } instrFormatT;

    typedef enum logic [5:0] {
        opStore = 6'b101100,
        opLoadS = 6'b101011,   // load into the float bank.
        opLoad  = 6'b101010,
        opJal   = 6'b101111,
        opJmp   = 6'b010000,
        opBez   = 6'b101110,
        opJreg  = 6'b101101
    } opcodeT;

    // function bits 5:4 of a register format word.
    typedef enum logic [1:0] {
        arith   = 2'b00,
        compare = 2'b01,
        float   = 2'b10,
        vector  = 2'b11
    } funcGroupT;

    // ########################################
    // field positions.
    // ########################################
    localparam int formatBit = 31;
    localparam int opcodeLsb = 26;
    localparam int opcodeW   = 6;
    localparam int destLsb   = 21;
    localparam int src1Lsb   = 16;
    localparam int src2Lsb   = 11;
    localparam int regIdxW   = 5;
    localparam int groupLsb  = 4;
    localparam int groupW    = 2;
    localparam int funcLsb   = 0;
    localparam int funcW     = 6;
    localparam int smallImmW = 16;
    localparam int largeImmW = 26;

endpackage

// ==== rtl/decodePkg.sv ====
package decodePkg;

    // register id, top bit selects the float bank.
    typedef logic [5:0] regIdT;

    // word handed in by the fetch source.
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
    } fetchPacketT;

    // decoded micro-op leaving a lane.
    typedef struct packed {
        logic [31:0] pc;
        regIdT       src1;
        regIdT       src2;
        regIdT       dest;
        logic [25:0] immData;
        logic        smallImm;
        logic        largeImm;
        logic [5:0]  funcCode;

        // memory and branch class.
        logic        isJal;
        logic        relJump;
        logic        absJump;
        logic        isLoad;
        logic        isStore;
        logic        uncondJump;
        logic        condJump;
    } microOpT;

endpackage

// ==== rtl/fetchDistributor.sv ====
`timescale 1ns/100ps
`include "decode_defines.svh"

module fetchDistributor (
    input  logic                                Clock,
    input  logic                                arstN,
    input  logic                                fetchValid,
    input  decodePkg::fetchPacketT              fetchPacket,
    output logic                                fetchCredit,
    output logic [`LANES-1:0]                   laneValid,
    output decodePkg::fetchPacketT [`LANES-1:0] lanePacket,
    input  logic [`LANES-1:0]                   laneCredit
);
    import decodePkg::*;

    localparam int ptrW  = (`FETCH_DEPTH > 1) ? $clog2(`FETCH_DEPTH) : 1;
    localparam int fillW = $clog2(`FETCH_DEPTH + 1);
    localparam int laneW = `LANE_PTR_W;
    localparam int credW = `LANE_CREDIT_W;
    localparam logic [ptrW-1:0]  lastSlot = ptrW'(`FETCH_DEPTH - 1);
    localparam logic [credW-1:0] laneInit = credW'(`LANE_DEPTH);

    fetchPacketT      fifoMem [`FETCH_DEPTH];
    logic [ptrW-1:0]  wrPtr;
    logic [ptrW-1:0]  rdPtr;
    logic [fillW-1:0] fill;
    logic [laneW-1:0] curLane;
    logic [credW-1:0] laneCredits [`LANES];
    logic             forward;

    // lanes are served strictly in turn, so a lane without credit stalls all.
    assign forward     = (fill != '0) && (laneCredits[curLane] != '0);
    assign fetchCredit = forward;   // entry freed as it leaves.

    always_comb begin
        for (int i = 0; i < `LANES; i++) begin
            laneValid[i]  = forward && (curLane == laneW'(i));
            lanePacket[i] = fifoMem[rdPtr];
        end
    end

    always_ff @(posedge Clock) begin
        if (fetchValid) fifoMem[wrPtr] <= fetchPacket;
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            fill    <= '0;
            curLane <= '0;
            for (int i = 0; i < `LANES; i++) laneCredits[i] <= laneInit;
        end else begin
            if (fetchValid) wrPtr <= (wrPtr == lastSlot) ? '0 : wrPtr + 1'b1;
            if (forward) begin
                rdPtr   <= (rdPtr == lastSlot) ? '0 : rdPtr + 1'b1;
                curLane <= curLane + 1'b1;   // wraps, lane count is a power of two.
            end
            case ({fetchValid, forward})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: ;
            endcase
            // ########################################
            // per lane credit bookkeeping.
            // ########################################
            for (int i = 0; i < `LANES; i++) begin
                case ({laneValid[i], laneCredit[i]})
                    2'b10:   laneCredits[i] <= laneCredits[i] - 1'b1;
                    2'b01:   laneCredits[i] <= laneCredits[i] + 1'b1;
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== rtl/decodeLane.sv ====
`timescale 1ns/100ps
`include "decode_defines.svh"

module decodeLane (
    input  logic                   Clock,
    input  logic                   arstN,
    input  logic                   inValid,
    input  decodePkg::fetchPacketT inPacket,
    output logic                   inCredit,
    output logic                   outValid,
    output decodePkg::microOpT     outUop,
    input  logic                   outCredit
);
    import isaPkg::*;
    import decodePkg::*;

    localparam int ptrW  = (`LANE_DEPTH > 1) ? $clog2(`LANE_DEPTH) : 1;
    localparam int credW = `LANE_CREDIT_W;
    localparam logic [ptrW-1:0]  lastSlot = ptrW'(`LANE_DEPTH - 1);
    localparam logic [credW-1:0] credInit = credW'(`LANE_DEPTH);

    fetchPacketT      queueMem [`LANE_DEPTH];
    logic [ptrW-1:0]  wrPtr;
    logic [ptrW-1:0]  rdPtr;
    logic [credW-1:0] fill;
    logic [credW-1:0] credits;
    logic             send;

    fetchPacketT        head;
    logic [31:0]        instr;
    opcodeT             opcode;
    instrFormatT        format;
    funcGroupT          group;
    logic               bankBit;
    logic [regIdxW-1:0] rdIdx;
    logic [regIdxW-1:0] rs1Idx;
    logic [regIdxW-1:0] rs2Idx;

    // ########################################
    // lane queue.
    // ########################################
    assign send     = (fill != '0) && (credits != '0);
    assign outValid = send;
    assign inCredit = send;

    always_ff @(posedge Clock) begin
        if (inValid) queueMem[wrPtr] <= inPacket;
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            fill    <= '0;
            credits <= credInit;
        end else begin
            if (inValid) wrPtr <= (wrPtr == lastSlot) ? '0 : wrPtr + 1'b1;
            if (send) rdPtr <= (rdPtr == lastSlot) ? '0 : rdPtr + 1'b1;
            case ({inValid, send})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: ;
            endcase
            case ({send, outCredit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ;
            endcase
        end
    end

    // ########################################
    // decode of the head word.
    // ########################################
    assign head   = queueMem[rdPtr];
    assign instr  = head.instr;
    assign opcode = opcodeT'(instr[opcodeLsb +: opcodeW]);
    assign group  = funcGroupT'(instr[groupLsb +: groupW]);
    assign rdIdx  = instr[destLsb +: regIdxW];
    assign rs1Idx = instr[src1Lsb +: regIdxW];
    assign rs2Idx = instr[src2Lsb +: regIdxW];

    assign format = instr[formatBit] ? immFormat :
                    (instr[formatBit-1] ? jumpFormat : regFormat);

    assign bankBit = (format == regFormat) && (group == float);   // float ops use the float bank.

    always_comb begin
        outUop    = '0;
        outUop.pc = head.pc;
        case (format)
            regFormat: begin
                outUop.src1     = {bankBit, rs1Idx};
                outUop.src2     = {bankBit, rs2Idx};
                outUop.dest     = {bankBit, rdIdx};
                outUop.funcCode = instr[funcLsb +: funcW];
            end
            jumpFormat: begin
                outUop.immData  = instr[0 +: largeImmW];
                outUop.largeImm = 1'b1;
            end
            immFormat: begin
                outUop.src1     = {1'b0, rs1Idx};
                outUop.src2     = (opcode == opStore) ? {1'b0, rdIdx} : '0;   // store data.
                outUop.dest     = {opcode == opLoadS, rdIdx};
                outUop.immData  = {{(largeImmW - smallImmW){instr[smallImmW-1]}},
                                   instr[0 +: smallImmW]};
                outUop.smallImm = 1'b1;
                // loads, store and jumps carry no function code.
                if (!(opcode >= opLoad && opcode <= opJal)) begin
                    outUop.funcCode = {1'b0, instr[opcodeLsb +: opcodeW-1]};
                end
            end
            default: ;
        endcase

        outUop.isJal      = (opcode == opJal);
        outUop.relJump    = (opcode == opJal) || (opcode == opJmp) || (opcode == opBez);
        outUop.absJump    = (opcode == opJreg);
        outUop.isLoad     = (opcode == opLoad) || (opcode == opLoadS);
        outUop.isStore    = (opcode == opStore);
        outUop.uncondJump = (opcode == opJreg) || (opcode == opJal) || (opcode == opJmp);
        outUop.condJump   = (opcode == opBez);
    end

endmodule

// ==== rtl/decodeCollector.sv ====
`timescale 1ns/100ps
`include "decode_defines.svh"

module decodeCollector (
    input  logic                              Clock,
    input  logic                              arstN,
    input  logic [`LANES-1:0]                 doneValid,
    input  decodePkg::microOpT [`LANES-1:0]   doneUop,
    output logic [`LANES-1:0]                 doneCredit,
    output logic                              uopValid,
    output decodePkg::microOpT                uop,
    input  logic                              uopCredit,
    input  logic [`UOP_CREDIT_W-1:0]          initialUopCredits
);
    import decodePkg::*;

    localparam int ptrW  = (`LANE_DEPTH > 1) ? $clog2(`LANE_DEPTH) : 1;
    localparam int fillW = `LANE_CREDIT_W;
    localparam int laneW = `LANE_PTR_W;
    localparam int uopW  = `UOP_CREDIT_W;
    localparam logic [ptrW-1:0] lastSlot = ptrW'(`LANE_DEPTH - 1);

    microOpT          retBuf [`LANES][`LANE_DEPTH];
    logic [ptrW-1:0]  wrPtr [`LANES];
    logic [ptrW-1:0]  rdPtr [`LANES];
    logic [fillW-1:0] fill [`LANES];
    logic [laneW-1:0] curLane;
    logic [uopW-1:0]  uopCredits;
    logic             creditsLoaded;
    logic             emit;

    // reading lanes in dealing order restores program order.
    assign emit     = (fill[curLane] != '0) && (uopCredits != '0);
    assign uopValid = emit;
    assign uop      = retBuf[curLane][rdPtr[curLane]];

    always_comb begin
        for (int i = 0; i < `LANES; i++) begin
            doneCredit[i] = emit && (curLane == laneW'(i));
        end
    end

    always_ff @(posedge Clock) begin
        for (int i = 0; i < `LANES; i++) begin
            if (doneValid[i]) retBuf[i][wrPtr[i]] <= doneUop[i];
        end
    end

    // ########################################
    // return buffer pointers.
    // ########################################
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            curLane <= '0;
            for (int i = 0; i < `LANES; i++) begin
                wrPtr[i] <= '0;
                rdPtr[i] <= '0;
                fill[i]  <= '0;
            end
        end else begin
            if (emit) curLane <= curLane + 1'b1;
            for (int i = 0; i < `LANES; i++) begin
                if (doneValid[i]) wrPtr[i] <= (wrPtr[i] == lastSlot) ? '0 : wrPtr[i] + 1'b1;
                if (doneCredit[i]) rdPtr[i] <= (rdPtr[i] == lastSlot) ? '0 : rdPtr[i] + 1'b1;
                case ({doneValid[i], doneCredit[i]})
                    2'b10:   fill[i] <= fill[i] + 1'b1;
                    2'b01:   fill[i] <= fill[i] - 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // output credits, the start count is taken on the first clock after reset.
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            uopCredits    <= '0;
            creditsLoaded <= 1'b0;
        end else if (!creditsLoaded) begin
            uopCredits    <= initialUopCredits;
            creditsLoaded <= 1'b1;
        end else begin
            case ({emit, uopCredit})
                2'b10:   uopCredits <= uopCredits - 1'b1;
                2'b01:   uopCredits <= uopCredits + 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// ==== rtl/decodeCluster.sv ====
`timescale 1ns/100ps
`include "decode_defines.svh"

module decodeCluster (
    input  logic                     Clock,
    input  logic                     arstN,
    input  logic                     fetchValid,
    input  decodePkg::fetchPacketT   fetchPacket,
    output logic                     fetchCredit,
    output logic                     uopValid,
    output decodePkg::microOpT       uop,
    input  logic                     uopCredit,
    input  logic [`UOP_CREDIT_W-1:0] initialUopCredits
);
    import decodePkg::*;

    logic [`LANES-1:0]              laneValid;
    fetchPacketT [`LANES-1:0]       lanePacket;
    logic [`LANES-1:0]              laneCredit;
    logic [`LANES-1:0]              doneValid;
    microOpT [`LANES-1:0]           doneUop;
    logic [`LANES-1:0]              doneCredit;

    fetchDistributor distributor0 (
        .Clock       (Clock),
        .arstN       (arstN),
        .fetchValid  (fetchValid),
        .fetchPacket (fetchPacket),
        .fetchCredit (fetchCredit),
        .laneValid   (laneValid),
        .lanePacket  (lanePacket),
        .laneCredit  (laneCredit)
    );

    for (genvar i = 0; i < `LANES; i++) begin : genLane
        decodeLane lane (
            .Clock     (Clock),
            .arstN     (arstN),
            .inValid   (laneValid[i]),
            .inPacket  (lanePacket[i]),
            .inCredit  (laneCredit[i]),
            .outValid  (doneValid[i]),
            .outUop    (doneUop[i]),
            .outCredit (doneCredit[i])
        );
    end

    decodeCollector collector0 (
        .Clock             (Clock),
        .arstN             (arstN),
        .doneValid         (doneValid),
        .doneUop           (doneUop),
        .doneCredit        (doneCredit),
        .uopValid          (uopValid),
        .uop               (uop),
        .uopCredit         (uopCredit),
        .initialUopCredits (initialUopCredits)
    );

endmodule

// ==== tests/clockGen.sv ====
`timescale 1ns/100ps

module clockGen (
    output logic Clock,
    output logic arstN,
    input  logic resetReq
);
    initial Clock = 1'b0;
    always #10 Clock = ~Clock;   // 20 ns period.

    // reset low for two rising edges, at start and again on each request.
    initial begin
        arstN = 1'b0;
        repeat (2) @(posedge Clock);
        #2 arstN = 1'b1;
        forever begin
            @(posedge resetReq);
            arstN = 1'b0;
            repeat (2) @(posedge Clock);
            #2 arstN = 1'b1;
        end
    end

endmodule

// ==== tests/decodeClusterTb.sv ====
`timescale 1ns/100ps
`include "decode_defines.svh"

module decodeClusterTb;
    import isaPkg::*;
    import decodePkg::*;

    localparam int numTable = 14;

    logic                     Clock;
    logic                     arstN;
    logic                     resetReq;
    logic                     fetchValid;
    fetchPacketT              fetchPacket;
    logic                     fetchCredit;
    logic                     uopValid;
    microOpT                  uop;
    logic                     uopCredit;
    logic [`UOP_CREDIT_W-1:0] initialUopCredits;

    logic [31:0] tableWord [numTable];
    logic [31:0] tablePc [numTable];
    microOpT     tableExp [numTable];
    microOpT     expected [$];   // scoreboard, program order.
    int errors, testsRun, testsFailed, checkedUops;
    int sourceCredits, creditPulses, sentCount, received, owed;
    bit creditReturnOn;
    bit aborted;

    clockGen clockGen0 (.Clock(Clock), .arstN(arstN), .resetReq(resetReq));

    decodeCluster dut0 (
        .Clock(Clock), .arstN(arstN), .fetchValid(fetchValid), .fetchPacket(fetchPacket),
        .fetchCredit(fetchCredit), .uopValid(uopValid), .uop(uop), .uopCredit(uopCredit),
        .initialUopCredits(initialUopCredits)
    );

    // ########################################
    // expected decode.
    // ########################################
    function automatic microOpT refDecode(input logic [31:0] word, input logic [31:0] pc);
        microOpT    u;
        logic [5:0] op;
        logic       fBank;
        begin
            u = '0;
            u.pc = pc;
            op = word[31:26];
            fBank = (word[5:4] == 2'b10);
            if (word[31]) begin
                u.src1 = {1'b0, word[20:16]};
                u.dest = {op == opLoadS, word[25:21]};
                u.immData = {{10{word[15]}}, word[15:0]};
                u.smallImm = 1'b1;
                if (op == opStore) u.src2 = {1'b0, word[25:21]};
                if (op < opLoad || op > opJal) u.funcCode = {1'b0, word[30:26]};
            end else if (word[30]) begin
                u.immData = word[25:0];
                u.largeImm = 1'b1;
            end else begin
                u.src1 = {fBank, word[20:16]};
                u.src2 = {fBank, word[15:11]};
                u.dest = {fBank, word[25:21]};
                u.funcCode = word[5:0];
            end
            u.isJal = (op == opJal);
            u.relJump = (op == opJal) || (op == opJmp) || (op == opBez);
            u.absJump = (op == opJreg);
            u.isLoad = (op == opLoad) || (op == opLoadS);
            u.isStore = (op == opStore);
            u.uncondJump = (op == opJreg) || (op == opJal) || (op == opJmp);
            u.condJump = (op == opBez);
            return u;
        end
    endfunction

    function automatic logic [31:0] randomWord(input int fmt);
        logic [31:0] w;
        begin
            w = $urandom;
            if (fmt == 0) w[31:30] = 2'b00;
            else if (fmt == 1) w[31:30] = 2'b01;
            else w[31] = 1'b1;
            return w;
        end
    endfunction

    task automatic buildTable();
        tableWord[0]  = {6'b000011, 5'd3, 5'd4, 5'd5, 5'd0, 6'b000101};     // arith.
        tableWord[1]  = {6'b001000, 5'd6, 5'd7, 5'd8, 5'd0, 6'b100010};     // float bank.
        tableWord[2]  = {6'b000001, 5'd9, 5'd10, 5'd11, 5'd0, 6'b010111};
        tableWord[3]  = {6'b001111, 5'd31, 5'd30, 5'd29, 5'd0, 6'b111000};
        tableWord[4]  = {6'b011010, 26'h2abcdef};
        tableWord[5]  = {opJmp, 26'h0001234};
        tableWord[6]  = {6'b100001, 5'd12, 5'd13, 16'h0010};
        tableWord[7]  = {6'b100100, 5'd14, 5'd15, 16'hfff0};                 // negative.
        tableWord[8]  = {opStore, 5'd16, 5'd17, 16'h0040};
        tableWord[9]  = {opLoad, 5'd18, 5'd19, 16'h8004};
        tableWord[10] = {opLoadS, 5'd20, 5'd21, 16'h0008};
        tableWord[11] = {opJal, 5'd22, 5'd23, 16'h0100};
        tableWord[12] = {opBez, 5'd24, 5'd25, 16'hff00};
        tableWord[13] = {opJreg, 5'd26, 5'd27, 16'h0000};
        for (int i = 0; i < numTable; i++) begin
            tablePc[i] = 32'h1000 + 4 * i;
            tableExp[i] = refDecode(tableWord[i], tablePc[i]);
        end
    endtask

    // ########################################
    // checks and drivers.
    // ########################################
    task automatic compareField(input string name, input logic [31:0] got,
                                input logic [31:0] exp, input logic [31:0] pc);
        if (got !== exp) begin
            $display("MISMATCH at %0t: pc %h field %s got %h expected %h",
                     $time, pc, name, got, exp);
            errors++;
        end
    endtask

    task automatic checkUop(input microOpT exp, input microOpT got);
        checkedUops++;
        compareField("pc", got.pc, exp.pc, exp.pc);
        compareField("src1", got.src1, exp.src1, exp.pc);
        compareField("src2", got.src2, exp.src2, exp.pc);
        compareField("dest", got.dest, exp.dest, exp.pc);
        compareField("immData", got.immData, exp.immData, exp.pc);
        compareField("immFlags", {got.smallImm, got.largeImm},
                     {exp.smallImm, exp.largeImm}, exp.pc);
        compareField("funcCode", got.funcCode, exp.funcCode, exp.pc);
        compareField("classFlags", got[6:0], exp[6:0], exp.pc);   // isJal down to condJump.
    endtask

    task automatic sendInstr(input logic [31:0] word, input logic [31:0] pc, input microOpT exp);
        int waitCycles;
        begin
            waitCycles = 0;
            @(posedge Clock);
            #2;
            while (sourceCredits == 0 && waitCycles < 200) begin
                fetchValid = 1'b0;
                waitCycles++;
                @(posedge Clock);
                #2;
            end
            if (sourceCredits == 0) begin
                $display("ERROR at %0t: no fetch credit came back within 200 cycles", $time);
                errors++;
                aborted = 1'b1;
                fetchValid = 1'b0;
            end else begin
                fetchValid = 1'b1;
                fetchPacket.instr = word;
                fetchPacket.pc = pc;
                sourceCredits--;
                sentCount++;
                expected.push_back(exp);
            end
        end
    endtask

    task automatic idleFetch();
        @(posedge Clock);
        #2 fetchValid = 1'b0;
    endtask

    task automatic waitReset();
        int c;
        begin
            c = 0;
            while (arstN !== 1'b1 && c < 20) begin
                @(posedge Clock);
                c++;
            end
            if (arstN !== 1'b1) begin
                $display("ERROR at %0t: reset was never released", $time);
                errors++;
                aborted = 1'b1;
            end
        end
    endtask

    task automatic applyReset(input logic [`UOP_CREDIT_W-1:0] credits);
        @(posedge Clock);
        #2;
        fetchValid = 1'b0;
        initialUopCredits = credits;
        resetReq = 1'b1;
        #1;
        expected.delete();
        owed = 0;
        received = 0;
        creditPulses = 0;
        sentCount = 0;
        sourceCredits = `FETCH_DEPTH;
        resetReq = 1'b0;
        waitReset();
    endtask

    task automatic waitDrain(input int limit);
        int c;
        begin
            c = 0;
            while (expected.size() != 0 && c < limit) begin
                @(posedge Clock);
                c++;
            end
            if (expected.size() != 0) begin
                $display("ERROR at %0t: %0d micro-ops never arrived", $time, expected.size());
                errors++;
                aborted = 1'b1;
            end
        end
    endtask

    task automatic reportTest(input string name, input int startErrors);
        testsRun++;
        if (errors == startErrors) begin
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: FAILED with %0d errors", name, errors - startErrors);
        end
    endtask

    // outputs are looked at mid cycle, well away from the rising edge.
    always @(negedge Clock) begin
        if (arstN === 1'b1) begin
            if (fetchCredit) begin
                creditPulses++;
                sourceCredits++;
                if (sourceCredits > `FETCH_DEPTH) begin
                    $display("ERROR at %0t: fetch credit returned for a packet never sent", $time);
                    errors++;
                end
            end
            if (uopValid) begin
                received++;
                owed++;
                if (expected.size() == 0) begin
                    $display("ERROR at %0t: micro-op for pc %h arrived unexpected", $time, uop.pc);
                    errors++;
                end else begin
                    checkUop(expected.pop_front(), uop);
                end
            end
        end
    end

    // consumer hands back one credit per cycle while any are owed.
    always @(posedge Clock) begin
        #2;
        if (arstN === 1'b1 && creditReturnOn && owed > 0) begin
            uopCredit = 1'b1;
            owed--;
        end else begin
            uopCredit = 1'b0;
        end
    end

    // ########################################
    // test sequence.
    // ########################################
    initial begin
        int startErrors;
        logic [31:0] word;
        void'($urandom(10));
        fetchValid = 1'b0;
        fetchPacket = '0;
        uopCredit = 1'b0;
        initialUopCredits = 8;
        resetReq = 1'b0;
        creditReturnOn = 1'b1;
        aborted = 1'b0;
        sourceCredits = `FETCH_DEPTH;
        buildTable();
        waitReset();

        startErrors = errors;
        for (int c = 0; c < 8; c++) begin
            @(negedge Clock);
            if (uopValid !== 1'b0 || fetchCredit !== 1'b0) begin
                $display("MISMATCH at %0t: uopValid or fetchCredit high with no input", $time);
                errors++;
            end
        end
        reportTest("reset", startErrors);

        startErrors = errors;
        for (int c = 0; c < numTable && !aborted; c++) begin
            sendInstr(tableWord[c], tablePc[c], tableExp[c]);
        end
        idleFetch();
        if (!aborted) waitDrain(300);
        reportTest("decode table", startErrors);

        startErrors = errors;
        for (int c = 0; c < 40 && !aborted; c++) begin
            word = randomWord($urandom % 3);
            sendInstr(word, 32'h2000 + 4 * c, refDecode(word, 32'h2000 + 4 * c));
        end
        idleFetch();
        if (!aborted) waitDrain(400);
        reportTest("program order", startErrors);

        startErrors = errors;
        creditReturnOn = 1'b0;
        if (!aborted) applyReset(3);
        for (int c = 0; c < 12 && !aborted; c++) begin
            word = randomWord($urandom % 3);
            sendInstr(word, 32'h3000 + 4 * c, refDecode(word, 32'h3000 + 4 * c));
        end
        idleFetch();
        for (int c = 0; c < 60; c++) @(posedge Clock);   // stall window.
        if (received != 3) begin
            $display("MISMATCH at %0t: %0d micro-ops under back-pressure, expected 3",
                     $time, received);
            errors++;
        end
        creditReturnOn = 1'b1;
        if (!aborted) waitDrain(400);
        reportTest("output back-pressure", startErrors);

        startErrors = errors;
        creditReturnOn = 1'b0;
        if (!aborted) applyReset(0);
        // lanes and return buffers fill first, then the input buffer takes the rest.
        for (int c = 0; c < 2 * `LANES * `LANE_DEPTH && !aborted; c++) begin
            word = randomWord($urandom % 3);
            sendInstr(word, 32'h4000 + 4 * c, refDecode(word, 32'h4000 + 4 * c));
        end
        for (int c = 0; c < `FETCH_DEPTH && !aborted; c++) begin
            word = randomWord($urandom % 3);
            sendInstr(word, 32'h5000 + 4 * c, refDecode(word, 32'h5000 + 4 * c));
        end
        idleFetch();
        for (int c = 0; c < 40; c++) @(posedge Clock);   // stall window.
        if (creditPulses != sentCount - `FETCH_DEPTH || received != 0) begin
            $display("MISMATCH at %0t: %0d fetch credits and %0d micro-ops for %0d stalled sends",
                     $time, creditPulses, received, sentCount);
            errors++;
        end
        owed = `UOP_CREDITS_MAX;   // grant output credits now.
        creditReturnOn = 1'b1;
        if (!aborted) waitDrain(400);
        @(posedge Clock);
        if (creditPulses != sentCount || sourceCredits != `FETCH_DEPTH) begin
            $display("MISMATCH at %0t: %0d fetch credits for %0d sends",
                     $time, creditPulses, sentCount);
            errors++;
        end
        reportTest("input credit accounting", startErrors);

        $display("tests %0d, failed %0d, micro-ops checked %0d, errors %0d",
                 testsRun, testsFailed, checkedUops, errors);
        if (errors == 0 && !aborted) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+rtl
rtl/isaPkg.sv
rtl/decodePkg.sv
rtl/fetchDistributor.sv
rtl/decodeLane.sv
rtl/decodeCollector.sv
rtl/decodeCluster.sv
tests/clockGen.sv
tests/decodeClusterTb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := decodeClusterTb
RTL_TOP    := decodeCluster
FILELIST   := sim.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --timescale 1ns/100ps -Wno-fatal --top-module $(TOP)
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/100ps --top-module $(RTL_TOP)
PASS_MSG   := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
